/* verilog/fightArena_defines.svh */
`ifndef FIGHTARENA_DEFINES_SVH
`define FIGHTARENA_DEFINES_SVH

// health and damage ------------------------------------------------------

// starting health per player in 9 bit registers
`define HEALTH_START 200

// damage per move type
`define DAMAGE_NORMAL 10
`define DAMAGE_SPECIAL 20
`define DAMAGE_SUPER 40

// combo timing, in game ticks ---------------------------------------------

// ticks during which new presses are ignored
`define COOLDOWN_TICKS 2
// window after cooldown where a special can chain into a super
`define CHAIN_TICKS 6

// attack queue entries
`define QUEUE_DEPTH 4

`endif

/* verilog/fightArenaPkg.sv */
`default_nettype none

package fightArenaPkg;

    // 0 means no attack, then normal, special and super
    typedef enum logic [1:0] {
        moveNone    = 2'd0,
        moveNormal  = 2'd1,
        moveSpecial = 2'd2,
        moveSuper   = 2'd3
    } comboMove_t;

    // round result
    typedef enum logic [1:0] {
        noWinner    = 2'd0,
        player1Wins = 2'd1,
        player2Wins = 2'd2
    } winner_t;

    // combo detector FSM
    typedef enum logic [1:0] {
        detIdle     = 2'd0,
        detCooldown = 2'd1,
        detChain    = 2'd2
    } detectState_t;

endpackage

`default_nettype wire

/* verilog/comboDetector.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fightArena_defines.svh"

module comboDetector (
    input  logic                      CLK_20Hz,
    input  logic                      rst,
    input  logic                      attackBtn,
    input  logic                      downBtn,
    output logic                      attackStrobe,
    output fightArenaPkg::comboMove_t move
);
    import fightArenaPkg::*;

    // counter reload values for the countdown to zero
    localparam logic [2:0] COOL_LOAD  = 3'(`COOLDOWN_TICKS - 1);
    localparam logic [2:0] CHAIN_LOAD = 3'(`CHAIN_TICKS - 1);

    detectState_t state;
    logic [2:0]   tickCount;
    logic         attackPrev;
    logic         lastSpecial;
    logic         attackRise;
    comboMove_t   nextMove;

    // edge detect ------------------------------------------------------------

    always_ff @(posedge CLK_20Hz)
    begin
        if (rst)
        begin
            attackPrev <= 1'b0;
        end
        else
        begin
            attackPrev <= attackBtn;
        end
    end

    assign attackRise = attackBtn && !attackPrev;

    // move classification
    // a special followed by a press in the chain window becomes a super
    always_comb
    begin
        if (state == detChain && lastSpecial)
            nextMove = moveSuper;
        else if (downBtn)
            nextMove = moveSpecial;
        else
            nextMove = moveNormal;
    end

    // combo FSM --------------------------------------------------------------

    always_ff @(posedge CLK_20Hz)
    begin
        if (rst)
        begin
            state        <= detIdle;
            tickCount    <= 3'd0;
            lastSpecial  <= 1'b0;
            attackStrobe <= 1'b0;
            move         <= moveNone;
        end
        else
        begin
            attackStrobe <= 1'b0;
            if (attackRise && state != detCooldown)
            begin
                // a new move restarts the cooldown
                attackStrobe <= 1'b1;
                move         <= nextMove;
                lastSpecial  <= (nextMove == moveSpecial);
                state        <= detCooldown;
                tickCount    <= COOL_LOAD;
            end
            else
            begin
                case (state)
                    detCooldown:
                    begin
                        if (tickCount == 3'd0)
                        begin
                            state     <= detChain;
                            tickCount <= CHAIN_LOAD;
                        end
                        else
                        begin
                            tickCount <= tickCount - 3'd1;
                        end
                    end
                    detChain:
                    begin
                        if (tickCount == 3'd0)
                        begin
                            // chain window closed
                            state       <= detIdle;
                            move        <= moveNone;
                            lastSpecial <= 1'b0;
                        end
                        else
                        begin
                            tickCount <= tickCount - 3'd1;
                        end
                    end
                    default:
                    begin
                        state <= detIdle;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/attackQueue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fightArena_defines.svh"

module attackQueue (
    input  logic                      CLK_20Hz,
    input  logic                      rst,
    input  logic                      push1,
    input  logic                      push2,
    input  logic                      pop,
    input  logic                      inRange,
    input  fightArenaPkg::comboMove_t move1,
    input  fightArenaPkg::comboMove_t move2,
    output logic                      notEmpty,
    output logic                      headAttacker,
    output logic                      headInRange,
    output logic                      attackDropped,
    output fightArenaPkg::comboMove_t headMove
);
    import fightArenaPkg::*;

    localparam int PTR_W = $clog2(`QUEUE_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    // entry storage
    comboMove_t moveMem     [`QUEUE_DEPTH];
    logic       attackerMem [`QUEUE_DEPTH];
    logic       rangeMem    [`QUEUE_DEPTH];

    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [PTR_W-1:0] wrPtr2;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] freeSlots;
    logic             popValid;
    logic             accept1;
    logic             accept2;

    // free space counts the pop of this same cycle
    assign popValid  = pop && (count != '0);
    assign freeSlots = CNT_W'(`QUEUE_DEPTH) - count + CNT_W'(popValid);

    // player 1 goes first so player 2 loses the last slot
    assign accept1 = push1 && (freeSlots >= CNT_W'(1));
    assign accept2 = push2 && (freeSlots >= (accept1 ? CNT_W'(2) : CNT_W'(1)));
    assign wrPtr2  = wrPtr + PTR_W'(accept1);

    always_ff @(posedge CLK_20Hz)
    begin
        if (accept1)
        begin
            moveMem[wrPtr]     <= move1;
            attackerMem[wrPtr] <= 1'b0;
            rangeMem[wrPtr]    <= inRange;
        end
        if (accept2)
        begin
            moveMem[wrPtr2]     <= move2;
            attackerMem[wrPtr2] <= 1'b1;
            rangeMem[wrPtr2]    <= inRange;
        end
    end

    // pointers and occupancy -------------------------------------------------

    always_ff @(posedge CLK_20Hz)
    begin
        if (rst)
        begin
            wrPtr         <= '0;
            rdPtr         <= '0;
            count         <= '0;
            attackDropped <= 1'b0;
        end
        else
        begin
            wrPtr         <= wrPtr + PTR_W'(accept1) + PTR_W'(accept2);
            rdPtr         <= rdPtr + PTR_W'(popValid);
            count         <= count + CNT_W'(accept1) + CNT_W'(accept2) - CNT_W'(popValid);
            attackDropped <= (push1 && !accept1) || (push2 && !accept2);
        end
    end

    assign notEmpty     = (count != '0);
    assign headMove     = moveMem[rdPtr];
    assign headAttacker = attackerMem[rdPtr];
    assign headInRange  = rangeMem[rdPtr];

endmodule

`default_nettype wire

/* verilog/healthManager.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fightArena_defines.svh"

module healthManager (
    input  logic                      CLK_20Hz,
    input  logic                      rst,
    input  logic                      notEmpty,
    input  logic                      headAttacker,
    input  logic                      headInRange,
    input  logic                      blockBtn1,
    input  logic                      blockBtn2,
    input  fightArenaPkg::comboMove_t headMove,
    output logic                      pop,
    output logic [8:0]                health1,
    output logic [8:0]                health2,
    output fightArenaPkg::winner_t    winner
);
    import fightArenaPkg::*;

    logic [8:0] baseDamage;
    logic [8:0] damage;
    logic [8:0] defenderHealth;
    logic [8:0] newHealth;
    logic       defenderBlocking;

    // one entry consumed per tick
    assign pop = notEmpty;

    // damage lookup ----------------------------------------------------------

    always_comb
    begin
        case (headMove)
            moveNormal:  baseDamage = 9'(`DAMAGE_NORMAL);
            moveSpecial: baseDamage = 9'(`DAMAGE_SPECIAL);
            moveSuper:   baseDamage = 9'(`DAMAGE_SUPER);
            default:     baseDamage = 9'd0;
        endcase
    end

    // attacker 0 hits player 2, attacker 1 hits player 1
    assign defenderBlocking = headAttacker ? blockBtn1 : blockBtn2;
    assign defenderHealth   = headAttacker ? health1 : health2;

    always_comb
    begin
        if (!headInRange)
            damage = 9'd0;
        else if (defenderBlocking)
            damage = baseDamage >> 1;
        else
            damage = baseDamage;
    end

    // saturate at zero
    assign newHealth = (defenderHealth > damage) ? defenderHealth - damage : 9'd0;

    // health and winner ------------------------------------------------------

    always_ff @(posedge CLK_20Hz)
    begin
        if (rst)
        begin
            health1 <= 9'(`HEALTH_START);
            health2 <= 9'(`HEALTH_START);
            winner  <= noWinner;
        end
        else if (pop && winner == noWinner)
        begin
            if (headAttacker)
                health1 <= newHealth;
            else
                health2 <= newHealth;

            // first player to hit zero loses, then everything freezes
            if (newHealth == 9'd0)
                winner <= headAttacker ? player2Wins : player1Wins;
        end
    end

endmodule

`default_nettype wire

/* verilog/fightArena.sv */
`timescale 1ns/1ps
`default_nettype none

module fightArena (
    input  logic                      CLK_20Hz,
    input  logic                      rst,
    input  logic                      attackBtn1,
    input  logic                      downBtn1,
    input  logic                      blockBtn1,
    input  logic                      attackBtn2,
    input  logic                      downBtn2,
    input  logic                      blockBtn2,
    input  logic                      inRange,
    output fightArenaPkg::comboMove_t move1,
    output fightArenaPkg::comboMove_t move2,
    output logic [8:0]                health1,
    output logic [8:0]                health2,
    output fightArenaPkg::winner_t    winner,
    output logic                      attackDropped
);
    import fightArenaPkg::*;

    logic       strobe1;
    logic       strobe2;
    logic       pop;
    logic       notEmpty;
    logic       headAttacker;
    logic       headInRange;
    comboMove_t headMove;

    // player input ------------------------------------------------------------

    comboDetector player1Combo (
        .CLK_20Hz     (CLK_20Hz),
        .rst          (rst),
        .attackBtn    (attackBtn1),
        .downBtn      (downBtn1),
        .attackStrobe (strobe1),
        .move         (move1)
    );

    comboDetector player2Combo (
        .CLK_20Hz     (CLK_20Hz),
        .rst          (rst),
        .attackBtn    (attackBtn2),
        .downBtn      (downBtn2),
        .attackStrobe (strobe2),
        .move         (move2)
    );

    // queue feeding the health logic
    attackQueue attackQueue_i (
        .CLK_20Hz      (CLK_20Hz),
        .rst           (rst),
        .push1         (strobe1),
        .push2         (strobe2),
        .pop           (pop),
        .inRange       (inRange),
        .move1         (move1),
        .move2         (move2),
        .notEmpty      (notEmpty),
        .headAttacker  (headAttacker),
        .headInRange   (headInRange),
        .attackDropped (attackDropped),
        .headMove      (headMove)
    );

    // hp management ------------------------------------------------------------

    healthManager healthManager_i (
        .CLK_20Hz     (CLK_20Hz),
        .rst          (rst),
        .notEmpty     (notEmpty),
        .headAttacker (headAttacker),
        .headInRange  (headInRange),
        .blockBtn1    (blockBtn1),
        .blockBtn2    (blockBtn2),
        .headMove     (headMove),
        .pop          (pop),
        .health1      (health1),
        .health2      (health2),
        .winner       (winner)
    );

endmodule

`default_nettype wire

/* verif/fightArenaTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fightArena_defines.svh"

module fightArenaTb;
    import fightArenaPkg::*;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 10;
    localparam int PRESS_TICKS  = 3;
    localparam int DRAIN_TICKS  = 12;
    // press and drain sequences over all tests including the knockout loop
    localparam int SEQUENCES    = 16;
    localparam int MAX_TICKS    = RESET_CYCLES + SEQUENCES * (PRESS_TICKS + DRAIN_TICKS + 1);
    localparam int MARGIN_TICKS = 50;

    logic       CLK_20Hz;
    logic       rst;
    logic       attackBtn1;
    logic       downBtn1;
    logic       blockBtn1;
    logic       attackBtn2;
    logic       downBtn2;
    logic       blockBtn2;
    logic       inRange;
    comboMove_t move1;
    comboMove_t move2;
    logic [8:0] health1;
    logic [8:0] health2;
    winner_t    winner;
    logic       attackDropped;

    int         errorCount;
    int         dropCount;
    int         expHealth1;
    int         expHealth2;
    winner_t    expWinner;

    fightArena fightArena_i (
        .CLK_20Hz      (CLK_20Hz),
        .rst           (rst),
        .attackBtn1    (attackBtn1),
        .downBtn1      (downBtn1),
        .blockBtn1     (blockBtn1),
        .attackBtn2    (attackBtn2),
        .downBtn2      (downBtn2),
        .blockBtn2     (blockBtn2),
        .inRange       (inRange),
        .move1         (move1),
        .move2         (move2),
        .health1       (health1),
        .health2       (health2),
        .winner        (winner),
        .attackDropped (attackDropped)
    );

    always #(CLK_PERIOD / 2) CLK_20Hz = ~CLK_20Hz;

    // count dropped pushes
    always @(negedge CLK_20Hz)
    begin
        if (!rst && attackDropped)
            dropCount++;
    end

    // helpers ----------------------------------------------------------------

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected)
        begin
            errorCount++;
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    task automatic expectRoundState();
        checkValue("health1", health1, expHealth1);
        checkValue("health2", health2, expHealth2);
        checkValue("winner", winner, expWinner);
    endtask

    // expected effect of one popped entry
    task automatic modelHit(input bit attacker, input comboMove_t mv, input bit range,
                            input bit block);
        int dmg;
        int defHp;
        if (expWinner != noWinner)
            return;
        case (mv)
            moveNormal:  dmg = `DAMAGE_NORMAL;
            moveSpecial: dmg = `DAMAGE_SPECIAL;
            moveSuper:   dmg = `DAMAGE_SUPER;
            default:     dmg = 0;
        endcase
        if (!range)
            dmg = 0;
        else if (block)
            dmg = dmg / 2;
        defHp = attacker ? expHealth1 : expHealth2;
        defHp = (defHp > dmg) ? defHp - dmg : 0;
        if (attacker)
            expHealth1 = defHp;
        else
            expHealth2 = defHp;
        if (defHp == 0)
            expWinner = attacker ? player2Wins : player1Wins;
    endtask

    // buttons held high for one tick
    task automatic pressAttack(input bit p1, input bit down1, input bit p2, input bit down2);
        @(posedge CLK_20Hz);
        attackBtn1 <= p1;
        downBtn1   <= down1;
        attackBtn2 <= p2;
        downBtn2   <= down2;
        @(posedge CLK_20Hz);
        attackBtn1 <= 1'b0;
        downBtn1   <= 1'b0;
        attackBtn2 <= 1'b0;
        downBtn2   <= 1'b0;
        @(negedge CLK_20Hz);
    endtask

    task automatic idleTicks(input int n);
        repeat (n) @(posedge CLK_20Hz);
        @(negedge CLK_20Hz);
    endtask

    // tests ------------------------------------------------------------------

    task automatic testReset();
        expectRoundState();
        checkValue("move1", move1, moveNone);
        checkValue("move2", move2, moveNone);
    endtask

    task automatic testNormalHits();
        pressAttack(1, 0, 0, 0);
        checkValue("move1", move1, moveNormal);
        modelHit(0, moveNormal, 1, 0);
        idleTicks(DRAIN_TICKS);
        expectRoundState();
        checkValue("move1", move1, moveNone);
        // defender blocking halves it
        @(posedge CLK_20Hz);
        blockBtn2 <= 1'b1;
        pressAttack(1, 0, 0, 0);
        modelHit(0, moveNormal, 1, 1);
        idleTicks(DRAIN_TICKS);
        expectRoundState();
        @(posedge CLK_20Hz);
        blockBtn2 <= 1'b0;
        inRange   <= 1'b0;
        pressAttack(1, 0, 0, 0);
        modelHit(0, moveNormal, 0, 0);
        idleTicks(DRAIN_TICKS);
        expectRoundState();
        @(posedge CLK_20Hz);
        inRange <= 1'b1;
    endtask

    task automatic testCombo();
        pressAttack(1, 1, 0, 0);
        checkValue("move1", move1, moveSpecial);
        modelHit(0, moveSpecial, 1, 0);
        // press during the cooldown is ignored
        pressAttack(1, 0, 0, 0);
        checkValue("move1", move1, moveSpecial);
        pressAttack(1, 0, 0, 0);
        checkValue("move1", move1, moveSuper);
        modelHit(0, moveSuper, 1, 0);
        idleTicks(DRAIN_TICKS);
        expectRoundState();
    endtask

    task automatic testSimultaneous();
        dropCount = 0;
        pressAttack(1, 0, 1, 1);
        checkValue("move1", move1, moveNormal);
        checkValue("move2", move2, moveSpecial);
        modelHit(0, moveNormal, 1, 0);
        modelHit(1, moveSpecial, 1, 0);
        idleTicks(DRAIN_TICKS);
        expectRoundState();
        checkValue("attackDropped count", dropCount, 0);
    endtask

    task automatic testKnockout();
        int combos;
        combos = 0;
        while (expHealth2 > 0 && combos < 4)
        begin
            pressAttack(1, 1, 0, 0);
            modelHit(0, moveSpecial, 1, 0);
            @(posedge CLK_20Hz);
            pressAttack(1, 0, 0, 0);
            checkValue("move1", move1, moveSuper);
            modelHit(0, moveSuper, 1, 0);
            idleTicks(DRAIN_TICKS);
            expectRoundState();
            combos++;
        end
        checkValue("winner", winner, player1Wins);
        // round over so health stays frozen
        pressAttack(1, 0, 1, 0);
        modelHit(0, moveNormal, 1, 0);
        modelHit(1, moveNormal, 1, 0);
        idleTicks(DRAIN_TICKS);
        expectRoundState();
    endtask

    // watchdog
    initial
    begin
        #((MAX_TICKS + MARGIN_TICKS) * CLK_PERIOD);
        $display("watchdog: the tests did not finish in the expected time");
        $display("test failed");
        $finish;
    end

    initial
    begin
        CLK_20Hz   = 1'b0;
        rst        = 1'b1;
        attackBtn1 = 1'b0;
        downBtn1   = 1'b0;
        blockBtn1  = 1'b0;
        attackBtn2 = 1'b0;
        downBtn2   = 1'b0;
        blockBtn2  = 1'b0;
        inRange    = 1'b1;
        errorCount = 0;
        dropCount  = 0;
        expHealth1 = `HEALTH_START;
        expHealth2 = `HEALTH_START;
        expWinner  = noWinner;

        repeat (RESET_CYCLES) @(posedge CLK_20Hz);
        rst <= 1'b0;
        @(negedge CLK_20Hz);

        testReset();
        testNormalHits();
        testCombo();
        testSimultaneous();
        testKnockout();

        $display("errors: %0d", errorCount);
        if (errorCount == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* fightArena.f */
+incdir+verilog
verilog/fightArenaPkg.sv
verilog/comboDetector.sv
verilog/attackQueue.sv
verilog/healthManager.sv
verilog/fightArena.sv
verif/fightArenaTb.sv

/* Bender.yml */
package:
  name: fightArena

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/fightArenaPkg.sv
      - verilog/comboDetector.sv
      - verilog/attackQueue.sv
      - verilog/healthManager.sv
      - verilog/fightArena.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verif/fightArenaTb.sv
